// ==== rob_pkg.sv ====
package rob_pkg;

    // core widths
    localparam int XLEN         = 32;
    localparam int REG_ADDR_LEN = 5;

    // buffer geometry
    localparam int ROB_SIZE    = 8;
    localparam int ROB_TAG_LEN = 3;
    localparam int ROB_CNT_LEN = 4;   // one extra bit so the count can reach ROB_SIZE

    typedef logic [ROB_TAG_LEN-1:0] rob_tag_t;

    // commit/recovery controller states
    typedef enum logic {
        RUN     = 1'b0,
        RECOVER = 1'b1   // dispatch held off for one cycle after flush
    } ctrl_state_t;

    // request from the front end, 69 bits
    typedef struct packed {
        logic [REG_ADDR_LEN-1:0] wb_reg;
        logic [XLEN-1:0]         pc;
        logic [XLEN-1:0]         npc;
    } dispatch_req_t;

    // result broadcast on the common data bus, 68 bits
    typedef struct packed {
        rob_tag_t        tag;
        logic [XLEN-1:0] wb_data;
        logic [XLEN-1:0] target_pc;   // only meaningful with mispredict
        logic            mispredict;
    } cdb_pkt_t;

    // one buffer slot, 104 bits
    typedef struct packed {
        logic                    valid;
        logic                    ready;
        logic                    mispredict;
        logic [REG_ADDR_LEN-1:0] wb_reg;
        logic [XLEN-1:0]         wb_data;
        logic [XLEN-1:0]         npc;
        logic [XLEN-1:0]         pc;
    } rob_entry_t;

    // retired instruction, 104 bits
    typedef struct packed {
        logic [REG_ADDR_LEN-1:0] wb_reg;
        logic [XLEN-1:0]         wb_data;
        logic [XLEN-1:0]         npc;   // target pc after a mispredict
        logic [XLEN-1:0]         pc;
        rob_tag_t                tag;
    } commit_t;

endpackage

// ==== rob_ptrs.sv ====
`timescale 1ns/1ps

module rob_ptrs (
    input  logic              clk,
    input  logic              reset,

    input  logic              alloc_en,
    input  logic              retire_en,
    input  logic              flush,

    output rob_pkg::rob_tag_t head,
    output rob_pkg::rob_tag_t tail,
    output logic              full,
    output logic              empty
);

    rob_pkg::rob_tag_t                 head_q;
    rob_pkg::rob_tag_t                 tail_q;
    logic [rob_pkg::ROB_CNT_LEN-1:0]   count_q;
    logic [rob_pkg::ROB_CNT_LEN-1:0]   count_d;

    // occupancy follows the two enables
    always_comb begin
        case ({alloc_en, retire_en})
            2'b10:   count_d = count_q + 1'b1;
            2'b01:   count_d = count_q - 1'b1;
            default: count_d = count_q;   // none, or one in and one out
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end
        else begin
            if (alloc_en) begin
                tail_q <= tail_q + 1'b1;   // wraps at ROB_SIZE
            end
            if (retire_en) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_d;
        end
    end

    assign head = head_q;
    assign tail = tail_q;

    // flags straight from the count, so all entries can be used
    assign full  = (count_q == rob_pkg::ROB_CNT_LEN'(rob_pkg::ROB_SIZE));
    assign empty = (count_q == '0);

endmodule

// ==== rob_entry_array.sv ====
`timescale 1ns/1ps

module rob_entry_array (
    input  logic                       clk,
    input  logic                       reset,

    // allocation from dispatch
    input  logic                       alloc_en,
    input  rob_pkg::rob_tag_t          alloc_tag,
    input  rob_pkg::dispatch_req_t     alloc_req,

    // completion
    input  logic                       cdb_valid,
    input  rob_pkg::cdb_pkt_t          cdb,

    // commit
    input  logic                       retire_en,
    input  rob_pkg::rob_tag_t          retire_tag,
    input  logic                       flush,

    // operand lookup
    input  rob_pkg::rob_tag_t          search_tag1,
    input  rob_pkg::rob_tag_t          search_tag2,
    output logic [rob_pkg::XLEN-1:0]   search_data1,
    output logic [rob_pkg::XLEN-1:0]   search_data2,

    output rob_pkg::rob_entry_t        head_entry
);

    // per-entry status bits
    logic [rob_pkg::ROB_SIZE-1:0] valid_q;
    logic [rob_pkg::ROB_SIZE-1:0] ready_q;
    logic [rob_pkg::ROB_SIZE-1:0] mispred_q;

    // payload storage
    logic [rob_pkg::REG_ADDR_LEN-1:0] wb_reg_q  [rob_pkg::ROB_SIZE];
    logic [rob_pkg::XLEN-1:0]         wb_data_q [rob_pkg::ROB_SIZE];
    logic [rob_pkg::XLEN-1:0]         npc_q     [rob_pkg::ROB_SIZE];
    logic [rob_pkg::XLEN-1:0]         pc_q      [rob_pkg::ROB_SIZE];

    // status update, flush drops everything incl. a same-cycle cdb write
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_q   <= '0;
            ready_q   <= '0;
            mispred_q <= '0;
        end
        else begin
            if (alloc_en) begin
                valid_q[alloc_tag]   <= 1'b1;
                ready_q[alloc_tag]   <= 1'b0;
                mispred_q[alloc_tag] <= 1'b0;
            end
            if (cdb_valid) begin
                ready_q[cdb.tag]   <= 1'b1;
                mispred_q[cdb.tag] <= cdb.mispredict;
            end
            if (retire_en) begin
                valid_q[retire_tag] <= 1'b0;   // head slot freed
            end
        end
    end

    // payload update
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            wb_reg_q[alloc_tag]  <= alloc_req.wb_reg;
            wb_data_q[alloc_tag] <= '0;   // filled in by the cdb
            npc_q[alloc_tag]     <= alloc_req.npc;
            pc_q[alloc_tag]      <= alloc_req.pc;
        end
        if (cdb_valid) begin
            wb_data_q[cdb.tag] <= cdb.wb_data;
            if (cdb.mispredict) begin
                npc_q[cdb.tag] <= cdb.target_pc;   // redirect on commit
            end
        end
    end

    // head entry for the commit controller
    always_comb begin
        head_entry.valid      = valid_q[retire_tag];
        head_entry.ready      = ready_q[retire_tag];
        head_entry.mispredict = mispred_q[retire_tag];
        head_entry.wb_reg     = wb_reg_q[retire_tag];
        head_entry.wb_data    = wb_data_q[retire_tag];
        head_entry.npc        = npc_q[retire_tag];
        head_entry.pc         = pc_q[retire_tag];
    end

    assign search_data1 = wb_data_q[search_tag1];
    assign search_data2 = wb_data_q[search_tag2];

endmodule

// ==== rob_commit_ctrl.sv ====
`timescale 1ns/1ps

module rob_commit_ctrl (
    input  logic                   clk,
    input  logic                   reset,

    input  rob_pkg::rob_entry_t    head_entry,
    input  rob_pkg::rob_tag_t      head,
    input  logic                   full,
    input  logic                   dispatch_valid,

    output logic                   alloc_en,
    output logic                   retire_en,
    output logic                   flush,

    output logic                   dispatch_ready,
    output logic                   commit_valid,
    output rob_pkg::commit_t       commit
);

    rob_pkg::ctrl_state_t state_q;
    rob_pkg::ctrl_state_t state_d;

    // a valid head already means the buffer holds something
    assign commit_valid = head_entry.valid && head_entry.ready;
    assign retire_en    = commit_valid;
    assign flush        = commit_valid && head_entry.mispredict;

    // no new work while full, flushing or recovering
    assign dispatch_ready = !full && !flush && (state_q == rob_pkg::RUN);
    assign alloc_en       = dispatch_valid && dispatch_ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            rob_pkg::RUN: begin
                if (flush) begin
                    state_d = rob_pkg::RECOVER;
                end
            end
            rob_pkg::RECOVER: begin
                state_d = rob_pkg::RUN;   // front end redirected by now
            end
            default: begin
                state_d = rob_pkg::RUN;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= rob_pkg::RUN;
        end
        else begin
            state_q <= state_d;
        end
    end

    // commit payload straight from the head slot
    always_comb begin
        commit.wb_reg  = head_entry.wb_reg;
        commit.wb_data = head_entry.wb_data;
        commit.npc     = head_entry.npc;
        commit.pc      = head_entry.pc;
        commit.tag     = head;
    end

endmodule

// ==== rob_top.sv ====
`timescale 1ns/1ps

module rob_top (
    input  logic                       clk,
    input  logic                       reset,

    // dispatch
    input  logic                       dispatch_valid,
    input  rob_pkg::dispatch_req_t     dispatch_req,
    output logic                       dispatch_ready,
    output rob_pkg::rob_tag_t          dispatch_tag,

    // completion bus
    input  logic                       cdb_valid,
    input  rob_pkg::cdb_pkt_t          cdb,

    // operand lookup
    input  rob_pkg::rob_tag_t          search_tag1,
    input  rob_pkg::rob_tag_t          search_tag2,
    output logic [rob_pkg::XLEN-1:0]   search_data1,
    output logic [rob_pkg::XLEN-1:0]   search_data2,

    // commit
    output logic                       commit_valid,
    output rob_pkg::commit_t           commit,
    output logic                       flush,

    output logic                       empty
);

    rob_pkg::rob_tag_t   head;
    rob_pkg::rob_tag_t   tail;
    logic                full;
    logic                alloc_en;
    logic                retire_en;
    rob_pkg::rob_entry_t head_entry;

    assign dispatch_tag = tail;   // new entry lands at the tail

    rob_ptrs u_ptrs (
        .clk       (clk),
        .reset     (reset),
        .alloc_en  (alloc_en),
        .retire_en (retire_en),
        .flush     (flush),
        .head      (head),
        .tail      (tail),
        .full      (full),
        .empty     (empty)
    );

    rob_entry_array u_array (
        .clk          (clk),
        .reset        (reset),
        .alloc_en     (alloc_en),
        .alloc_tag    (tail),
        .alloc_req    (dispatch_req),
        .cdb_valid    (cdb_valid),
        .cdb          (cdb),
        .retire_en    (retire_en),
        .retire_tag   (head),
        .flush        (flush),
        .search_tag1  (search_tag1),
        .search_tag2  (search_tag2),
        .search_data1 (search_data1),
        .search_data2 (search_data2),
        .head_entry   (head_entry)
    );

    rob_commit_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .head_entry     (head_entry),
        .head           (head),
        .full           (full),
        .dispatch_valid (dispatch_valid),
        .alloc_en       (alloc_en),
        .retire_en      (retire_en),
        .flush          (flush),
        .dispatch_ready (dispatch_ready),
        .commit_valid   (commit_valid),
        .commit         (commit)
    );

endmodule

// ==== tb_rob.sv ====
`timescale 1ns/1ps

module tb_rob;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int TEST_COUNT   = 5;
    localparam int TEST_CYCLES  = 80;   // generous per-test budget
    localparam int WATCHDOG_NS  =
        CLK_PERIOD * (TEST_COUNT * (RESET_CYCLES + TEST_CYCLES) + 20);

    logic                         clk;
    logic                         reset;
    logic                         dispatch_valid;
    rob_pkg::dispatch_req_t       dispatch_req;
    logic                         dispatch_ready;
    rob_pkg::rob_tag_t            dispatch_tag;
    logic                         cdb_valid;
    rob_pkg::cdb_pkt_t            cdb;
    rob_pkg::rob_tag_t            search_tag1;
    rob_pkg::rob_tag_t            search_tag2;
    logic [rob_pkg::XLEN-1:0]     search_data1;
    logic [rob_pkg::XLEN-1:0]     search_data2;
    logic                         commit_valid;
    rob_pkg::commit_t             commit;
    logic                         flush;
    logic                         empty;

    // reference model of the buffer
    rob_pkg::rob_tag_t            pending [$];   // dispatched tags, oldest first
    rob_pkg::dispatch_req_t       m_req    [rob_pkg::ROB_SIZE];
    logic [rob_pkg::XLEN-1:0]     m_data   [rob_pkg::ROB_SIZE];
    logic [rob_pkg::XLEN-1:0]     m_target [rob_pkg::ROB_SIZE];
    logic                         m_mis    [rob_pkg::ROB_SIZE];
    rob_pkg::rob_tag_t            m_tail;
    int                           commits;
    int                           seed = 90;
    string                        test_name;

    rob_top u_dut (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_req   (dispatch_req),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .cdb_valid      (cdb_valid),
        .cdb            (cdb),
        .search_tag1    (search_tag1),
        .search_tag2    (search_tag2),
        .search_data1   (search_data1),
        .search_data2   (search_data2),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .flush          (flush),
        .empty          (empty)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_stop("timeout: the tests did not finish in the expected time");
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_tag(input rob_pkg::rob_tag_t exp, input rob_pkg::rob_tag_t act);
        if (exp !== act) begin
            fail_stop($sformatf("FAIL %s: expected tag %0d, actual %0d", test_name, exp, act));
        end
    endtask

    task automatic check_data(input logic [rob_pkg::XLEN-1:0] exp,
                              input logic [rob_pkg::XLEN-1:0] act);
        if (exp !== act) begin
            fail_stop($sformatf("FAIL %s: expected data %h, actual %h", test_name, exp, act));
        end
    endtask

    task automatic check_commit(input rob_pkg::commit_t exp, input rob_pkg::commit_t act);
        if (exp !== act) begin
            fail_stop($sformatf("FAIL %s: expected commit %h, actual %h", test_name, exp, act));
        end
    endtask

    task automatic check_bit(input logic exp, input logic act);
        if (exp !== act) begin
            fail_stop($sformatf("FAIL %s: expected %b, actual %b", test_name, exp, act));
        end
    endtask

    // commits checked mid-cycle against the oldest pending tag
    always @(negedge clk) begin : commit_monitor
        rob_pkg::rob_tag_t tag;
        rob_pkg::commit_t  exp;
        if (!reset) begin
            if (commit_valid) begin
                if (pending.size() == 0) begin
                    fail_stop("commit seen while the model holds no entry");
                end
                tag         = pending.pop_front();
                exp.wb_reg  = m_req[tag].wb_reg;
                exp.wb_data = m_data[tag];
                exp.npc     = m_mis[tag] ? m_target[tag] : m_req[tag].npc;
                exp.pc      = m_req[tag].pc;
                exp.tag     = tag;
                check_commit(exp, commit);
                check_bit(m_mis[tag], flush);
                commits++;
                if (m_mis[tag]) begin
                    pending.delete();   // younger work is squashed
                    m_tail = '0;
                end
            end
            else begin
                check_bit(1'b0, flush);
            end
        end
    end

    function automatic rob_pkg::dispatch_req_t make_req(input logic [31:0] base, input int i);
        rob_pkg::dispatch_req_t req;
        req.wb_reg = rob_pkg::REG_ADDR_LEN'(i + 1);
        req.pc     = base + 32'(4 * i);
        req.npc    = base + 32'(4 * i + 4);
        return req;
    endfunction

    task automatic apply_reset;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        cdb_valid      = 1'b0;
        pending.delete();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset   = 1'b0;
        m_tail  = '0;
        commits = 0;
        #2;
        check_bit(1'b0, commit_valid);
        check_bit(1'b0, flush);
        check_bit(1'b1, dispatch_ready);
        check_bit(1'b1, empty);
        @(posedge clk);
        #1;
    endtask

    // called mid-cycle once dispatch_valid and dispatch_ready are both high
    task automatic record_dispatch(input rob_pkg::dispatch_req_t req,
                                   output rob_pkg::rob_tag_t tag);
        tag = dispatch_tag;
        check_tag(m_tail, tag);
        m_req[tag]  = req;
        m_data[tag] = '0;
        m_mis[tag]  = 1'b0;
        pending.push_back(tag);
        m_tail = m_tail + 1'b1;
    endtask

    task automatic dispatch_one(input rob_pkg::dispatch_req_t req,
                                output rob_pkg::rob_tag_t tag, output int waited);
        dispatch_valid = 1'b1;
        dispatch_req   = req;
        waited         = 0;
        #2;
        while (!dispatch_ready) begin
            if (waited == 40) begin
                fail_stop("dispatch_ready stayed low for 40 cycles");
            end
            waited++;
            @(posedge clk);
            #3;
        end
        record_dispatch(req, tag);
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
    endtask

    task automatic cdb_write(input rob_pkg::rob_tag_t tag, input logic [31:0] data,
                             input logic mis, input logic [31:0] target);
        cdb_valid      = 1'b1;
        cdb.tag        = tag;
        cdb.wb_data    = data;
        cdb.target_pc  = target;
        cdb.mispredict = mis;
        m_data[tag]    = data;
        m_mis[tag]     = mis;
        m_target[tag]  = target;
        @(posedge clk);
        #1;
        cdb_valid = 1'b0;
    endtask

    task automatic wait_commits(input int n);
        int waited;
        waited = 0;
        while (commits < n) begin
            if (waited == 40) begin
                fail_stop("expected commits did not arrive within 40 cycles");
            end
            waited++;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic test_in_order_commit;
        rob_pkg::rob_tag_t tag;
        int                waited;
        test_name = "in_order_commit";
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            dispatch_one(make_req(32'h0000_1000, i), tag, waited);
            check_tag(rob_pkg::ROB_TAG_LEN'(i), tag);
        end
        cdb_write(3'd2, $random(seed), 1'b0, '0);
        cdb_write(3'd0, $random(seed), 1'b0, '0);
        cdb_write(3'd3, $random(seed), 1'b0, '0);
        cdb_write(3'd1, $random(seed), 1'b0, '0);
        wait_commits(4);   // monitor checks order and payload
        #2;
        check_bit(1'b1, empty);
        @(posedge clk);
        #1;
    endtask

    task automatic test_full_backpressure;
        rob_pkg::rob_tag_t      tag;
        rob_pkg::dispatch_req_t req;
        int                     waited;
        test_name = "full_backpressure";
        apply_reset();
        for (int i = 0; i < rob_pkg::ROB_SIZE; i++) begin
            dispatch_one(make_req(32'h0000_2000, i), tag, waited);
        end
        req            = make_req(32'h0000_2000, 8);
        dispatch_valid = 1'b1;   // held while refused
        dispatch_req   = req;
        repeat (3) begin
            #2;
            check_bit(1'b0, dispatch_ready);
            check_tag(3'd0, dispatch_tag);
            @(posedge clk);
            #1;
        end
        cdb_write(3'd0, $random(seed), 1'b0, '0);
        wait_commits(1);
        dispatch_one(req, tag, waited);
        check_tag(3'd0, tag);   // tail wrapped
        #2;
        check_bit(1'b0, dispatch_ready);
        @(posedge clk);
        #1;
    endtask

    task automatic test_search_ports;
        rob_pkg::rob_tag_t        tag;
        int                       waited;
        logic [rob_pkg::XLEN-1:0] d1;
        logic [rob_pkg::XLEN-1:0] d2;
        test_name = "search_ports";
        apply_reset();
        for (int i = 0; i < 3; i++) begin
            dispatch_one(make_req(32'h0000_3000, i), tag, waited);
        end
        d1 = $random(seed);
        d2 = $random(seed);
        cdb_write(3'd1, d1, 1'b0, '0);   // tag 0 stays busy, nothing commits
        cdb_write(3'd2, d2, 1'b0, '0);
        search_tag1 = 3'd1;
        search_tag2 = 3'd2;
        #2;
        check_data(d1, search_data1);
        check_data(d2, search_data2);
        @(posedge clk);
        #1;
        search_tag1 = 3'd2;
        search_tag2 = 3'd1;
        #2;
        check_data(d2, search_data1);
        check_data(d1, search_data2);
        @(posedge clk);
        #1;
    endtask

    task automatic test_mispredict_flush;
        rob_pkg::rob_tag_t tag;
        int                waited;
        test_name = "mispredict_flush";
        apply_reset();
        for (int i = 0; i < 3; i++) begin
            dispatch_one(make_req(32'h0000_4000, i), tag, waited);
        end
        cdb_write(3'd1, $random(seed), 1'b0, '0);   // younger result, squashed below
        cdb_write(3'd0, $random(seed), 1'b1, $random(seed));
        #2;   // commit cycle
        check_bit(1'b1, commit_valid);
        check_bit(1'b1, flush);
        check_bit(1'b0, dispatch_ready);
        @(posedge clk);
        #3;
        check_bit(1'b1, empty);
        check_bit(1'b0, dispatch_ready);
        @(posedge clk);
        #1;
        dispatch_one(make_req(32'h0000_4800, 0), tag, waited);
        if (waited != 0) begin
            fail_stop("dispatch_ready did not return one cycle after recovery");
        end
        check_tag(3'd0, tag);
        cdb_write(3'd0, $random(seed), 1'b0, '0);
        wait_commits(2);   // old tag 1 must not come back
        #2;
        check_bit(1'b0, commit_valid);
        check_bit(1'b1, empty);
        @(posedge clk);
        #1;
    endtask

    task automatic test_dispatch_with_commit;
        rob_pkg::rob_tag_t tag;
        int                waited;
        int                free;
        int                accepted;
        test_name = "dispatch_with_commit";
        apply_reset();
        for (int i = 0; i < 3; i++) begin
            dispatch_one(make_req(32'h0000_5000, i), tag, waited);
        end
        cdb_write(3'd0, $random(seed), 1'b0, '0);
        dispatch_one(make_req(32'h0000_5000, 3), tag, waited);
        if (waited != 0 || commits != 1) begin
            fail_stop("the dispatch was not accepted in the cycle of the commit");
        end
        free     = rob_pkg::ROB_SIZE - pending.size();
        accepted = 0;
        dispatch_valid = 1'b1;
        dispatch_req   = make_req(32'h0000_5000, 4);
        #2;
        while (dispatch_ready) begin
            if (accepted == rob_pkg::ROB_SIZE) begin
                fail_stop("dispatch_ready did not drop on a full buffer");
            end
            record_dispatch(dispatch_req, tag);
            accepted++;
            @(posedge clk);
            #1;
            dispatch_req = make_req(32'h0000_5000, 4 + accepted);
            #2;
        end
        if (accepted != free) begin
            fail_stop($sformatf("FAIL %s: expected %0d dispatches, actual %0d",
                                test_name, free, accepted));
        end
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
    endtask

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_req   = '0;
        cdb_valid      = 1'b0;
        cdb            = '0;
        search_tag1    = '0;
        search_tag2    = '0;
        test_in_order_commit();
        test_full_backpressure();
        test_search_ports();
        test_mispredict_flush();
        test_dispatch_with_commit();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== src.f ====
rob_pkg.sv
rob_ptrs.sv
rob_entry_array.sv
rob_commit_ctrl.sv
rob_top.sv
tb_rob.sv
